// File: source/perceptron_pkg.sv
package perceptron_pkg;

	// global history length, also the number of history weights per row.
	localparam int bhr_w = 8;

	// one signed weight and its saturation limits.
	localparam int weight_w = 8;
	localparam int weight_max = (1 << (weight_w - 1)) - 1;
	localparam int weight_min = -(1 << (weight_w - 1));

	// the table is indexed by the low bits of the branch PC.
	localparam int pt_idx_w = 6;
	localparam int pt_depth = 1 << pt_idx_w;

	// nine weights of eight bits fit in twelve signed bits.
	localparam int sum_w = 12;

	// training threshold, floor(1.93 * bhr_w + 14).
	localparam int theta = 29;

	localparam int pc_w = 64;

endpackage

// File: source/pt_table.sv
module pt_table
	import perceptron_pkg::*;
(
	input	logic									clk,
	input	logic									rst,

	// fetch side read port.
	input	logic [pt_idx_w-1:0]					pt_rd1_idx_i,
	// resolution side read port.
	input	logic [pt_idx_w-1:0]					pt_rd2_idx_i,

	input	logic									pt_wr_en_i,
	input	logic [pt_idx_w-1:0]					pt_wr_idx_i,
	input	logic signed [bhr_w:0][weight_w-1:0]	pt_wr_weight_i,

	output	logic signed [bhr_w:0][weight_w-1:0]	pt_rd1_weight_o,
	output	logic signed [bhr_w:0][weight_w-1:0]	pt_rd2_weight_o
);

	logic signed [bhr_w:0][weight_w-1:0]	mem [pt_depth];

	logic	rd1_hit;
	logic	rd2_hit;

	// every row starts at zero so that each branch initially predicts taken.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < pt_depth; r++) begin
				mem[r] <= '0;
			end
		end else if (pt_wr_en_i) begin
			mem[pt_wr_idx_i] <= pt_wr_weight_i;
		end
	end

	assign rd1_hit = pt_wr_en_i && (pt_wr_idx_i == pt_rd1_idx_i);
	assign rd2_hit = pt_wr_en_i && (pt_wr_idx_i == pt_rd2_idx_i);

	// a write in flight is forwarded so reads in the same cycle see the trained row.
	always_comb begin
		if (rd1_hit) begin
			pt_rd1_weight_o = pt_wr_weight_i;
		end else begin
			pt_rd1_weight_o = mem[pt_rd1_idx_i];
		end
	end

	always_comb begin
		if (rd2_hit) begin
			pt_rd2_weight_o = pt_wr_weight_i;	// back-to-back updates to one index.
		end else begin
			pt_rd2_weight_o = mem[pt_rd2_idx_i];
		end
	end

endmodule

// File: source/predict.sv
module predict
	import perceptron_pkg::*;
(
	input	logic signed [bhr_w:0][weight_w-1:0]	weight_i,
	input	logic [bhr_w-1:0]						bhr_i,

	output	logic signed [sum_w-1:0]				sum_o,
	output	logic									taken_o
);

	logic signed [weight_w-1:0]	w [bhr_w+1];	// row split into individually signed weights.
	logic signed [sum_w-1:0]	acc;

	// indexing a packed array drops the sign, so each element is recast here.
	always_comb begin
		for (int k = 0; k <= bhr_w; k++) begin
			w[k] = signed'(weight_i[k]);
		end
	end

	// weight k+1 pairs with history bit k; weight 0 is the bias.
	always_comb begin
		acc = w[0];
		for (int i = 0; i < bhr_w; i++) begin
			if (bhr_i[i]) begin
				acc = acc + w[i+1];
			end else begin
				acc = acc - w[i+1];
			end
		end
	end

	assign sum_o = acc;

	assign taken_o = ~acc[sum_w-1];	// a sum of zero counts as taken.

endmodule

// File: source/train.sv
module train
	import perceptron_pkg::*;
(
	input	logic									clk,
	input	logic									rst,

	input	logic									update_i,
	input	logic									br_taken_i,
	input	logic [pt_idx_w-1:0]					br_idx_i,
	input	logic [bhr_w-1:0]						bhr_i,
	input	logic signed [bhr_w:0][weight_w-1:0]	weight_i,

	output	logic signed [bhr_w:0][weight_w-1:0]	new_weight_o,
	output	logic [pt_idx_w-1:0]					wr_idx_o,
	output	logic									wr_en_o
);

	logic signed [sum_w-1:0]				sum;
	logic									taken;
	logic [sum_w-1:0]						sum_mag;
	logic									mispredict;
	logic									low_conf;
	logic									train_cond;

	logic signed [weight_w-1:0]				old_w [bhr_w+1];
	logic signed [bhr_w:0][weight_w-1:0]	next_row;

	// one step toward the target, held at the limits.
	function automatic logic signed [weight_w-1:0] sat_step(
		input logic signed [weight_w-1:0]	w,
		input logic							up
	);
		logic signed [weight_w-1:0] res;
		if (up) begin
			res = (w == weight_max) ? w : w + 8'sd1;
		end else begin
			res = (w == weight_min) ? w : w - 8'sd1;
		end
		return res;
	endfunction

	// recompute the sum with the history as it stood when the branch resolved.
	predict u_recompute (
		.weight_i	(weight_i),
		.bhr_i		(bhr_i),
		.sum_o		(sum),
		.taken_o	(taken)
	);

	assign sum_mag = sum[sum_w-1] ? -sum : sum;

	assign mispredict = (taken != br_taken_i);
	assign low_conf = (sum_mag <= sum_w'(theta));
	assign train_cond = mispredict || low_conf;

	always_comb begin
		for (int k = 0; k <= bhr_w; k++) begin
			old_w[k] = signed'(weight_i[k]);
		end
	end

	// stage 1. the bias follows the outcome, each history weight follows agreement.
	always_comb begin
		next_row[0] = sat_step(old_w[0], br_taken_i);
		for (int i = 0; i < bhr_w; i++) begin
			next_row[i+1] = sat_step(old_w[i+1], bhr_i[i] == br_taken_i);
		end
	end

	// stage 2. the write goes out one cycle after the update strobe.
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_en_o <= 1'b0;
		end else begin
			wr_en_o <= update_i && train_cond;
		end
	end

	always_ff @(posedge clk) begin
		new_weight_o <= next_row;
		wr_idx_o <= br_idx_i;
	end

endmodule

// File: source/perceptron.sv
module perceptron
	import perceptron_pkg::*;
(
	input	logic				clk,
	input	logic				rst,

	// fetch stage.
	input	logic [pc_w-1:0]	if2pt_pc_i,

	// resolved branch from the functional unit.
	input	logic				fu2pt_done_i,
	input	logic				fu2pt_cond_br_i,
	input	logic				fu2pt_br_taken_i,
	input	logic [pc_w-1:0]	fu2pt_br_pc_i,

	output	logic				prediction_o
);

	logic [bhr_w-1:0]						bhr;
	logic									update;

	logic [pt_idx_w-1:0]					fetch_idx;
	logic [pt_idx_w-1:0]					br_idx;

	logic signed [bhr_w:0][weight_w-1:0]	fetch_row;
	logic signed [bhr_w:0][weight_w-1:0]	br_row;

	logic									pt_wr_en;
	logic [pt_idx_w-1:0]					pt_wr_idx;
	logic signed [bhr_w:0][weight_w-1:0]	pt_wr_row;

	// only resolved conditional branches train the table or enter the history.
	assign update = fu2pt_done_i && fu2pt_cond_br_i;

	assign fetch_idx = if2pt_pc_i[pt_idx_w-1:0];
	assign br_idx = fu2pt_br_pc_i[pt_idx_w-1:0];

	// newest outcome enters at bit 0.
	always_ff @(posedge clk) begin
		if (rst) begin
			bhr <= '0;
		end else if (update) begin
			bhr <= {bhr[bhr_w-2:0], fu2pt_br_taken_i};
		end
	end

	pt_table u_table (
		.clk				(clk),
		.rst				(rst),
		.pt_rd1_idx_i		(fetch_idx),
		.pt_rd2_idx_i		(br_idx),
		.pt_wr_en_i			(pt_wr_en),
		.pt_wr_idx_i		(pt_wr_idx),
		.pt_wr_weight_i		(pt_wr_row),
		.pt_rd1_weight_o	(fetch_row),
		.pt_rd2_weight_o	(br_row)
	);

	// the fetch prediction only needs the sign of the sum.
	predict u_predict (
		.weight_i	(fetch_row),
		.bhr_i		(bhr),
		.sum_o		(),
		.taken_o	(prediction_o)
	);

	train u_train (
		.clk			(clk),
		.rst			(rst),
		.update_i		(update),
		.br_taken_i		(fu2pt_br_taken_i),
		.br_idx_i		(br_idx),
		.bhr_i			(bhr),			// history before this branch is shifted in.
		.weight_i		(br_row),
		.new_weight_o	(pt_wr_row),
		.wr_idx_o		(pt_wr_idx),
		.wr_en_o		(pt_wr_en)
	);

endmodule

// File: verif/clk_gen.sv
module clk_gen (
	output	logic	clk_o
);

	// a full period of 4 time units.
	initial begin
		clk_o = 1'b0;
		forever begin
			#2 clk_o = ~clk_o;
		end
	end

endmodule

// File: verif/perceptron_props.sv
module perceptron_props
	import perceptron_pkg::*;
(
	input	logic				clk,
	input	logic				rst,
	input	logic				update_i,
	input	logic				wr_en_i,
	input	logic [bhr_w-1:0]	bhr_i
);

	int fail_count = 0;	// read by the testbench for its closing report.

	// the trainer's write stage is empty right after reset.
	wr_en_after_reset: assert property (@(posedge clk) $fell(rst) |-> !wr_en_i)
	else begin
		fail_count++;
		$error("table write enable high in the first cycle after reset");
	end

	// a write only ever follows an update strobe by one cycle.
	wr_en_follows_update: assert property (@(posedge clk) disable iff (rst)
		wr_en_i |-> $past(update_i))
	else begin
		fail_count++;
		$error("table write enable without an update strobe in the cycle before");
	end

	// the history moves only on an update strobe.
	history_holds: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) && !$past(update_i) |-> bhr_i == $past(bhr_i))
	else begin
		fail_count++;
		$error("history register changed in a cycle without an update strobe");
	end

endmodule

bind perceptron perceptron_props u_props (
	.clk		(clk),
	.rst		(rst),
	.update_i	(update),
	.wr_en_i	(pt_wr_en),
	.bhr_i		(bhr)
);

// File: verif/perceptron_tb.sv
module perceptron_tb
	import perceptron_pkg::*;
();

	logic				clk;
	logic				rst;
	logic [pc_w-1:0]	if2pt_pc;
	logic				fu2pt_done;
	logic				fu2pt_cond_br;
	logic				fu2pt_br_taken;
	logic [pc_w-1:0]	fu2pt_br_pc;
	logic				prediction;

	int					m_w [pt_depth][bhr_w+1];	// reference weight table.
	logic [bhr_w-1:0]	m_bhr;
	logic [31:0]		lfsr_state;

	int					check_count;
	int					error_count;
	int					timeout_count;
	int					total_errors;

	clk_gen u_clk_gen (
		.clk_o	(clk)
	);

	perceptron uut (
		.clk				(clk),
		.rst				(rst),
		.if2pt_pc_i			(if2pt_pc),
		.fu2pt_done_i		(fu2pt_done),
		.fu2pt_cond_br_i	(fu2pt_cond_br),
		.fu2pt_br_taken_i	(fu2pt_br_taken),
		.fu2pt_br_pc_i		(fu2pt_br_pc),
		.prediction_o		(prediction)
	);

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;	// x^32 + x^22 + x^2 + x + 1.
		end
		return n;
	endfunction

	// one LFSR step for every bit taken.
	task automatic take_bits(input int n, output logic [pc_w-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = galois_step(lfsr_state);
			v = {v[pc_w-2:0], lfsr_state[0]};
		end
	endtask

	task automatic model_clear();
		for (int r = 0; r < pt_depth; r++) begin
			for (int k = 0; k <= bhr_w; k++) begin
				m_w[r][k] = 0;
			end
		end
		m_bhr = '0;
	endtask

	function automatic int model_sum(input int idx);
		int s;
		s = m_w[idx][0];
		for (int i = 0; i < bhr_w; i++) begin
			if (m_bhr[i]) begin
				s = s + m_w[idx][i+1];
			end else begin
				s = s - m_w[idx][i+1];
			end
		end
		return s;
	endfunction

	function automatic logic model_predict(input logic [pc_w-1:0] pc);
		return model_sum(int'(pc[pt_idx_w-1:0])) >= 0;
	endfunction

	function automatic int sat_add(input int w, input int d);
		int r;
		r = w + d;
		if (r > weight_max) begin
			r = weight_max;
		end
		if (r < weight_min) begin
			r = weight_min;
		end
		return r;
	endfunction

	// threshold training of one row, then the outcome enters the history.
	task automatic model_resolve(input logic [pc_w-1:0] pc, input logic taken);
		int idx;
		int s;
		int mag;
		idx = int'(pc[pt_idx_w-1:0]);
		s = model_sum(idx);
		mag = (s < 0) ? -s : s;
		if (((s >= 0) != taken) || mag <= theta) begin
			m_w[idx][0] = sat_add(m_w[idx][0], taken ? 1 : -1);
			for (int i = 0; i < bhr_w; i++) begin
				m_w[idx][i+1] = sat_add(m_w[idx][i+1], (m_bhr[i] == taken) ? 1 : -1);
			end
		end
		m_bhr = {m_bhr[bhr_w-2:0], taken};
	endtask

	task automatic check_prediction(input logic expected, input string msg);
		check_count++;
		if (prediction !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s, prediction %b, expected %b",
				$time, msg, prediction, expected);
		end
	endtask

	task automatic check_history(input logic [bhr_w-1:0] expected, input string msg);
		check_count++;
		if (uut.bhr !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s, history %b, expected %b", $time, msg, uut.bhr, expected);
		end
	endtask

	// drive one cycle, check at the falling edge, then let the model see the strobe.
	task automatic step(
		input logic [pc_w-1:0]	fetch_pc,
		input logic				done,
		input logic				cond_br,
		input logic				taken,
		input logic [pc_w-1:0]	br_pc,
		input string			msg
	);
		@(posedge clk);
		if2pt_pc <= fetch_pc;
		fu2pt_done <= done;
		fu2pt_cond_br <= cond_br;
		fu2pt_br_taken <= taken;
		fu2pt_br_pc <= br_pc;
		@(negedge clk);
		check_prediction(model_predict(fetch_pc), msg);
		check_history(m_bhr, msg);
		if (done && cond_br) begin
			model_resolve(br_pc, taken);
		end
	endtask

	task automatic idle(input logic [pc_w-1:0] fetch_pc, input string msg);
		step(fetch_pc, 1'b0, 1'b0, 1'b0, '0, msg);
	endtask

	task automatic resolve(input logic [pc_w-1:0] pc, input logic taken, input string msg);
		step(pc, 1'b1, 1'b1, taken, pc, msg);
	endtask

	task automatic test_after_reset();
		logic [pc_w-1:0] pc;
		for (int i = 0; i < pt_depth; i++) begin
			take_bits(pc_w, pc);
			pc[pt_idx_w-1:0] = pt_idx_w'(i);
			idle(pc, $sformatf("reset state, index %0d", i));
			check_prediction(1'b1, $sformatf("zero row predicts taken, index %0d", i));
		end
	endtask

	task automatic test_never_taken();
		logic [pc_w-1:0] pc_a;
		logic [pc_w-1:0] pc_b;
		int tries;
		pc_a = 64'h0000_0000_0040_1a04;
		pc_b = 64'h0000_0000_0040_1a08;
		tries = 0;
		do begin
			resolve(pc_a, 1'b0, "never-taken resolution");
			idle(pc_a, "never-taken prediction");
			tries++;
		end while (prediction !== 1'b0 && tries < 20);
		if (prediction !== 1'b0) begin
			timeout_count++;
			$display("timeout: never-taken branch still predicted taken after %0d resolutions",
				tries);
		end
		// keep training until the sum is past the threshold and training stops.
		tries = 0;
		while (model_sum(int'(pc_a[pt_idx_w-1:0])) >= -theta && tries < 20) begin
			resolve(pc_a, 1'b0, "never-taken confidence");
			tries++;
		end
		if (model_sum(int'(pc_a[pt_idx_w-1:0])) >= -theta) begin
			timeout_count++;
			$display("timeout: never-taken branch still training after %0d resolutions",
				tries);
		end
		resolve(pc_a, 1'b0, "never-taken after threshold");
		idle(pc_a, "never-taken settled");
		check_prediction(1'b0, "trained branch predicts not taken");
		idle(pc_b, "untrained index");
		check_prediction(1'b1, "untrained index predicts taken");
	endtask

	task automatic test_alternating();
		logic [pc_w-1:0] pc_c;
		logic outcome;
		int streak;
		int tries;
		pc_c = 64'h0000_0000_0040_2c4c;
		outcome = 1'b1;
		streak = 0;
		tries = 0;
		while (streak < 8 && tries < 200) begin
			resolve(pc_c, outcome, "alternating resolution");
			outcome = ~outcome;
			idle(pc_c, "alternating prediction");
			if (prediction === outcome) begin
				streak++;
			end else begin
				streak = 0;
			end
			tries++;
		end
		if (streak < 8) begin
			timeout_count++;
			$display("timeout: alternating branch not learned after %0d resolutions", tries);
		end
	endtask

	task automatic test_back_to_back();
		logic [pc_w-1:0] pc_d;
		logic [pc_w-1:0] bits;
		logic pred_before;
		logic [bhr_w-1:0] hist_before;
		pc_d = 64'h0000_0000_0041_0061;
		for (int i = 0; i < 24; i++) begin
			take_bits(1, bits);
			resolve(pc_d, bits[0], $sformatf("back-to-back resolution %0d", i));
		end
		idle(pc_d, "after back-to-back");
		pred_before = model_predict(pc_d);
		hist_before = m_bhr;
		// done without cond_br, and cond_br without done, change nothing.
		for (int i = 0; i < 4; i++) begin
			take_bits(1, bits);
			step(pc_d, 1'b1, 1'b0, bits[0], pc_d, "unconditional strobe");
		end
		step(pc_d, 1'b0, 1'b1, 1'b1, pc_d, "cond_br without done");
		idle(pc_d, "after ignored strobes");
		check_prediction(pred_before, "prediction held across ignored strobes");
		check_history(hist_before, "history held across ignored strobes");
	endtask

	task automatic test_random_mix();
		logic [pc_w-1:0] br_pc;
		logic [pc_w-1:0] fetch_pc;
		logic [pc_w-1:0] bits;
		for (int i = 0; i < 400; i++) begin
			take_bits(pc_w, br_pc);
			take_bits(pc_w, fetch_pc);
			take_bits(3, bits);
			step(fetch_pc, 1'b1, bits[2:1] != 2'b00, bits[0], br_pc,
				$sformatf("random mix %0d", i));
			idle(br_pc, $sformatf("random mix follow-up %0d", i));
		end
	endtask

	task automatic test_long_run();
		logic [pc_w-1:0] pc_e;
		logic [pc_w-1:0] other;
		pc_e = 64'h0000_0000_0042_0f3e;
		for (int i = 0; i < 256; i++) begin
			take_bits(pc_w, other);
			step(pc_e, 1'b1, 1'b1, 1'b1, pc_e, $sformatf("long run %0d", i));
			step(other, 1'b1, 1'b1, 1'b1, pc_e, $sformatf("long run cross fetch %0d", i));
		end
		idle(pc_e, "after long run");
		check_prediction(1'b1, "long taken run predicts taken");
	endtask

	initial begin
		rst = 1'b1;
		if2pt_pc = '0;
		// a mispredicting strobe held through reset must neither train nor shift.
		fu2pt_done = 1'b1;
		fu2pt_cond_br = 1'b1;
		fu2pt_br_taken = 1'b0;
		fu2pt_br_pc = '0;
		lfsr_state = 32'hf7ee;
		check_count = 0;
		error_count = 0;
		timeout_count = 0;
		model_clear();

		repeat (8) @(posedge clk);
		rst <= 1'b0;
		fu2pt_done <= 1'b0;
		fu2pt_cond_br <= 1'b0;

		test_after_reset();
		test_never_taken();
		test_alternating();
		test_back_to_back();
		test_random_mix();
		test_long_run();
		idle('0, "final cycle");

		total_errors = error_count + timeout_count + uut.u_props.fail_count;
		$display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
			check_count, error_count, timeout_count, uut.u_props.fail_count);
		if (total_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: src.f
source/perceptron_pkg.sv
source/pt_table.sv
source/predict.sv
source/train.sv
source/perceptron.sv
verif/clk_gen.sv
verif/perceptron_props.sv
verif/perceptron_tb.sv
